// ==== common/periph_pkg.sv ====
/*
 * Peripheral subsystem shared definitions
 * Bus widths, address map, and the AXI4-Lite and register request types
 */
package periph_pkg;

    // ------------------------------
    // Widths and address map
    // ------------------------------
    localparam int DataWidth = 32;
    localparam int StrbWidth = DataWidth / 8;
    localparam int AddrWidth = 16;
    localparam int RegionMsb = 15;
    localparam int RegionLsb = 12;

    localparam logic [RegionMsb-RegionLsb:0] PlicRegion  = 4'd0;
    localparam logic [RegionMsb-RegionLsb:0] TimerRegion = 4'd1;

    // Returned by the error responder
    localparam logic [DataWidth-1:0] ErrorData = 32'hDEAD_BEEF;

    localparam int NumTimers  = 2;
    localparam int NumSources = 6;
    localparam int SrcIdWidth = 3;
    localparam int NumTargets = 2;
    localparam int PrioWidth  = 3;

    // ------------------------------
    // Types
    // ------------------------------
    typedef enum logic [1:0] {
        RespOkay   = 2'b00,
        RespSlvErr = 2'b10
    } resp_e;

    typedef struct packed {
        logic                 aw_valid;
        logic [AddrWidth-1:0] aw_addr;
        logic                 w_valid;
        logic [DataWidth-1:0] w_data;
        logic [StrbWidth-1:0] w_strb;
        logic                 b_ready;
        logic                 ar_valid;
        logic [AddrWidth-1:0] ar_addr;
        logic                 r_ready;
    } axil_req_t;

    typedef struct packed {
        logic                 aw_ready;
        logic                 w_ready;
        logic                 b_valid;
        resp_e                b_resp;
        logic                 ar_ready;
        logic                 r_valid;
        logic [DataWidth-1:0] r_data;
        resp_e                r_resp;
    } axil_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        logic [StrbWidth-1:0] wstrb;
    } reg_req_t;

    typedef struct packed {
        logic                 ready;
        logic [DataWidth-1:0] rdata;
        logic                 error;
    } reg_rsp_t;

    // Bit s-1 belongs to source s
    typedef logic [NumSources-1:0] src_vec_t;
    typedef logic [PrioWidth-1:0]  prio_t;

    // Merge the strobed bytes of a write into a register value
    function automatic logic [DataWidth-1:0] apply_strb(
        logic [DataWidth-1:0] old_val,
        logic [DataWidth-1:0] wdata,
        logic [StrbWidth-1:0] strb
    );
        logic [DataWidth-1:0] res;
        res = old_val;
        for (int b = 0; b < StrbWidth; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== verilog/axil_reg_bridge.sv ====
/*
 * AXI4-Lite slave to register bridge
 * One transaction at a time becomes a single-cycle register request
 */
module axil_reg_bridge (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::axil_req_t axil_req_i,
    output periph_pkg::axil_rsp_t axil_rsp_o,
    output periph_pkg::reg_req_t  reg_req_o,
    input  periph_pkg::reg_rsp_t  reg_rsp_i
);
    import periph_pkg::*;

    typedef enum logic [1:0] {
        Idle,
        WriteCollect,
        Access,
        Respond
    } state_e;

    state_e               state_q;
    logic                 have_aw_q;
    logic                 have_w_q;
    logic                 write_q;
    logic [AddrWidth-1:0] addr_q;
    logic [DataWidth-1:0] wdata_q;
    logic [StrbWidth-1:0] wstrb_q;
    logic [DataWidth-1:0] rdata_q;
    resp_e                resp_q;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 ar_hs;
    logic                 rsp_taken;

    // ------------------------------
    // Channel handshakes
    // ------------------------------
    // A pending write blocks the read address channel, so writes go first
    assign axil_rsp_o.aw_ready = (state_q == Idle) || (state_q == WriteCollect && !have_aw_q);
    assign axil_rsp_o.w_ready  = (state_q == Idle) || (state_q == WriteCollect && !have_w_q);
    assign axil_rsp_o.ar_ready = (state_q == Idle) && !axil_req_i.aw_valid
                                 && !axil_req_i.w_valid;

    assign axil_rsp_o.b_valid = (state_q == Respond) && write_q;
    assign axil_rsp_o.b_resp  = resp_q;
    assign axil_rsp_o.r_valid = (state_q == Respond) && !write_q;
    assign axil_rsp_o.r_data  = rdata_q;
    assign axil_rsp_o.r_resp  = resp_q;

    assign aw_hs = axil_req_i.aw_valid && axil_rsp_o.aw_ready;
    assign w_hs  = axil_req_i.w_valid && axil_rsp_o.w_ready;
    assign ar_hs = axil_req_i.ar_valid && axil_rsp_o.ar_ready;
    assign rsp_taken = write_q ? axil_req_i.b_ready : axil_req_i.r_ready;

    assign reg_req_o.valid = (state_q == Access);
    assign reg_req_o.write = write_q;
    assign reg_req_o.addr  = addr_q;
    assign reg_req_o.wdata = wdata_q;
    assign reg_req_o.wstrb = wstrb_q;

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= Idle;
            have_aw_q <= 1'b0;
            have_w_q  <= 1'b0;
            write_q   <= 1'b0;
        end else begin
            case (state_q)
                Idle, WriteCollect: begin
                    if (aw_hs) have_aw_q <= 1'b1;
                    if (w_hs) have_w_q <= 1'b1;
                    if ((have_aw_q || aw_hs) && (have_w_q || w_hs)) begin
                        state_q <= Access;
                        write_q <= 1'b1;
                    end else if (aw_hs || w_hs) begin
                        state_q <= WriteCollect;
                    end else if (ar_hs) begin
                        state_q <= Access;
                        write_q <= 1'b0;
                    end
                end
                Access: begin
                    have_aw_q <= 1'b0;
                    have_w_q  <= 1'b0;
                    if (reg_rsp_i.ready) state_q <= Respond;
                end
                default: begin
                    if (rsp_taken) state_q <= Idle;
                end
            endcase
        end
    end

    // Address, write data and the answer
    always_ff @(posedge clk_i) begin
        if (aw_hs) addr_q <= axil_req_i.aw_addr;
        if (ar_hs) addr_q <= axil_req_i.ar_addr;
        if (w_hs) begin
            wdata_q <= axil_req_i.w_data;
            wstrb_q <= axil_req_i.w_strb;
        end
        if (state_q == Access && reg_rsp_i.ready) begin
            rdata_q <= reg_rsp_i.rdata;
            resp_q  <= reg_rsp_i.error ? RespSlvErr : RespOkay;
        end
    end

    a_one_response: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(axil_rsp_o.b_valid && axil_rsp_o.r_valid));

    a_single_cycle_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_req_o.valid |=> !reg_req_o.valid);

endmodule

// ==== verilog/reg_demux.sv ====
/*
 * Register request decoder
 * Routes by region to the PLIC or the timers, and answers unmapped regions with an error
 */
module reg_demux (
    input  periph_pkg::reg_req_t reg_req_i,
    output periph_pkg::reg_rsp_t reg_rsp_o,
    output periph_pkg::reg_req_t plic_req_o,
    input  periph_pkg::reg_rsp_t plic_rsp_i,
    output periph_pkg::reg_req_t timer_req_o,
    input  periph_pkg::reg_rsp_t timer_rsp_i
);
    import periph_pkg::*;

    logic [RegionMsb-RegionLsb:0] region;
    logic [AddrWidth-1:0]         offset;

    assign region = reg_req_i.addr[RegionMsb:RegionLsb];
    assign offset = AddrWidth'(reg_req_i.addr[RegionLsb-1:0]);

    // Slaves see only the offset inside their region
    always_comb begin
        plic_req_o        = reg_req_i;
        plic_req_o.addr   = offset;
        plic_req_o.valid  = reg_req_i.valid && (region == PlicRegion);
        timer_req_o       = reg_req_i;
        timer_req_o.addr  = offset;
        timer_req_o.valid = reg_req_i.valid && (region == TimerRegion);
    end

    always_comb begin
        case (region)
            PlicRegion:  reg_rsp_o = plic_rsp_i;
            TimerRegion: reg_rsp_o = timer_rsp_i;
            default: begin
                // Error responder
                reg_rsp_o.ready = 1'b1;
                reg_rsp_o.rdata = ErrorData;
                reg_rsp_o.error = 1'b1;
            end
        endcase
    end

endmodule

// ==== timer/timer_unit.sv ====
/*
 * Timer block with two free-running counters
 * Compare match, optional clear on match, and overflow flags as interrupts
 */
module timer_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::reg_req_t reg_req_i,
    output periph_pkg::reg_rsp_t reg_rsp_o,
    output logic [3:0]           irq_o
);
    import periph_pkg::*;

    logic [DataWidth-1:0] cnt_q    [NumTimers];
    logic [DataWidth-1:0] cmp_q    [NumTimers];
    logic [1:0]           ctrl_q   [NumTimers];
    logic [1:0]           status_q [NumTimers];
    logic [AddrWidth-5:0] sel;

    // Timer n sits at 0x10 * n, register in bits 3:2
    assign sel = reg_req_i.addr[AddrWidth-1:4];

    for (genvar n = 0; n < NumTimers; n++) begin : g_timer
        logic wr_sel;
        logic match;
        logic clear;

        assign wr_sel = reg_req_i.valid && reg_req_i.write && (sel == (AddrWidth-4)'(n));
        assign match  = (cnt_q[n] == cmp_q[n]);
        assign clear  = match && ctrl_q[n][1];
        assign irq_o[2*n +: 2] = status_q[n];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                cnt_q[n]    <= '0;
                cmp_q[n]    <= '1;
                ctrl_q[n]   <= '0;
                status_q[n] <= '0;
            end else begin
                // CTRL bit 0 enables counting
                if (ctrl_q[n][0]) begin
                    cnt_q[n] <= clear ? '0 : cnt_q[n] + 1'b1;
                    if (match) status_q[n][0] <= 1'b1;
                    if (!clear && &cnt_q[n]) status_q[n][1] <= 1'b1;
                end
                // Register writes take priority over counting
                if (wr_sel) begin
                    case (reg_req_i.addr[3:2])
                        2'd0: cnt_q[n] <= apply_strb(cnt_q[n], reg_req_i.wdata, reg_req_i.wstrb);
                        2'd1: cmp_q[n] <= apply_strb(cmp_q[n], reg_req_i.wdata, reg_req_i.wstrb);
                        2'd2: ctrl_q[n] <= reg_req_i.wdata[1:0];
                        default: status_q[n] <= status_q[n] & ~reg_req_i.wdata[1:0];
                    endcase
                end
            end
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------
    always_comb begin
        reg_rsp_o.ready = 1'b1;
        reg_rsp_o.error = 1'b0;
        reg_rsp_o.rdata = '0;
        for (int n = 0; n < NumTimers; n++) begin
            if (sel == (AddrWidth-4)'(n)) begin
                case (reg_req_i.addr[3:2])
                    2'd0:    reg_rsp_o.rdata = cnt_q[n];
                    2'd1:    reg_rsp_o.rdata = cmp_q[n];
                    2'd2:    reg_rsp_o.rdata = DataWidth'(ctrl_q[n]);
                    default: reg_rsp_o.rdata = DataWidth'(status_q[n]);
                endcase
            end
        end
    end

endmodule

// ==== plic/plic_gateway.sv ====
/*
 * PLIC gateway for level-triggered sources
 * Tracks pending and in-flight state per source
 */
module plic_gateway (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::src_vec_t src_i,
    input  periph_pkg::src_vec_t claim_i,
    input  periph_pkg::src_vec_t complete_i,
    output periph_pkg::src_vec_t pending_o
);
    import periph_pkg::*;

    src_vec_t pending_q;
    src_vec_t inflight_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            // No new request from a source until its handler completes
            pending_q  <= (pending_q | (src_i & ~inflight_q)) & ~claim_i;
            inflight_q <= (inflight_q | claim_i) & ~complete_i;
        end
    end

    assign pending_o = pending_q;

    // Targets may only claim what the gateway reports as pending
    a_claim_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (claim_i & ~pending_q) == '0);

endmodule

// ==== plic/plic_target.sv ====
/*
 * PLIC target arbiter
 * Highest-priority enabled pending source above the threshold, lowest ID on a tie
 */
module plic_target (
    input  periph_pkg::src_vec_t                        pending_i,
    input  periph_pkg::src_vec_t                        enable_i,
    input  periph_pkg::prio_t [periph_pkg::NumSources-1:0] prio_i,
    input  periph_pkg::prio_t                           threshold_i,
    output logic [periph_pkg::SrcIdWidth-1:0]           max_id_o
);
    import periph_pkg::*;

    prio_t best_prio;

    // Strict compare in ascending order keeps the lowest ID on equal priority
    always_comb begin
        best_prio = threshold_i;
        max_id_o  = '0;
        for (int s = 0; s < NumSources; s++) begin
            if (pending_i[s] && enable_i[s] && (prio_i[s] > best_prio)) begin
                best_prio = prio_i[s];
                max_id_o  = SrcIdWidth'(s + 1);
            end
        end
    end

endmodule

// ==== plic/plic_regs.sv ====
/*
 * PLIC register file
 * Priorities, enables, thresholds and claim/complete for two targets
 */
module plic_regs (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  periph_pkg::reg_req_t             reg_req_i,
    output periph_pkg::reg_rsp_t             reg_rsp_o,
    input  periph_pkg::src_vec_t             src_i,
    output logic [periph_pkg::NumTargets-1:0] irq_o
);
    import periph_pkg::*;

    prio_t [NumSources-1:0]  prio_q;
    src_vec_t                enable_q    [NumTargets];
    prio_t                   threshold_q [NumTargets];
    logic [SrcIdWidth-1:0]   max_id      [NumTargets];
    src_vec_t                pending;
    src_vec_t                claim;
    src_vec_t                complete;
    logic [AddrWidth-1:0]    addr;
    logic                    rd_req;
    logic                    wr_req;

    assign addr   = reg_req_i.addr;
    assign rd_req = reg_req_i.valid && !reg_req_i.write;
    assign wr_req = reg_req_i.valid && reg_req_i.write;

    plic_gateway u_gateway (
        .clk_i      ( clk_i    ),
        .rst_n_i    ( rst_n_i  ),
        .src_i      ( src_i    ),
        .claim_i    ( claim    ),
        .complete_i ( complete ),
        .pending_o  ( pending  )
    );

    for (genvar t = 0; t < NumTargets; t++) begin : g_target
        plic_target u_target (
            .pending_i   ( pending        ),
            .enable_i    ( enable_q[t]    ),
            .prio_i      ( prio_q         ),
            .threshold_i ( threshold_q[t] ),
            .max_id_o    ( max_id[t]      )
        );
        assign irq_o[t] = (max_id[t] != '0);
    end

    // ------------------------------
    // Register writes
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prio_q <= '0;
            for (int t = 0; t < NumTargets; t++) begin
                enable_q[t]    <= '0;
                threshold_q[t] <= '0;
            end
        end else if (wr_req) begin
            for (int s = 0; s < NumSources; s++) begin
                if (addr == AddrWidth'(4 * (s + 1))) prio_q[s] <= reg_req_i.wdata[PrioWidth-1:0];
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (addr == AddrWidth'('h100 + 4 * t)) begin
                    enable_q[t] <= reg_req_i.wdata[NumSources-1:0];
                end
                if (addr == AddrWidth'('h200 + 16 * t)) begin
                    threshold_q[t] <= reg_req_i.wdata[PrioWidth-1:0];
                end
            end
        end
    end

    // ------------------------------
    // Reads, claim and complete
    // ------------------------------
    always_comb begin
        reg_rsp_o.ready = 1'b1;
        reg_rsp_o.error = 1'b0;
        reg_rsp_o.rdata = '0;
        claim           = '0;
        complete        = '0;
        for (int s = 0; s < NumSources; s++) begin
            if (addr == AddrWidth'(4 * (s + 1))) reg_rsp_o.rdata = DataWidth'(prio_q[s]);
        end
        if (addr == AddrWidth'('h080)) reg_rsp_o.rdata = DataWidth'(pending);
        for (int t = 0; t < NumTargets; t++) begin
            if (addr == AddrWidth'('h100 + 4 * t)) reg_rsp_o.rdata = DataWidth'(enable_q[t]);
            if (addr == AddrWidth'('h200 + 16 * t)) reg_rsp_o.rdata = DataWidth'(threshold_q[t]);
            if (addr == AddrWidth'('h204 + 16 * t)) begin
                reg_rsp_o.rdata = DataWidth'(max_id[t]);
                // Reading the claim register takes the winning source
                if (rd_req && max_id[t] != '0) claim[max_id[t] - 1'b1] = 1'b1;
                if (wr_req && reg_req_i.wdata != '0 && reg_req_i.wdata <= NumSources) begin
                    complete[reg_req_i.wdata[SrcIdWidth-1:0] - 1'b1] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/periph_subsystem.sv ====
/*
 * Peripheral subsystem top level
 * AXI4-Lite bridge, address decode, two timers and the PLIC
 */
module periph_subsystem (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::axil_req_t axil_req_i,
    output periph_pkg::axil_rsp_t axil_rsp_o,
    input  logic [1:0]            ext_irq_i,
    output logic [1:0]            irq_o
);
    import periph_pkg::*;

    reg_req_t   bus_req;
    reg_rsp_t   bus_rsp;
    reg_req_t   plic_req;
    reg_rsp_t   plic_rsp;
    reg_req_t   timer_req;
    reg_rsp_t   timer_rsp;
    logic [3:0] timer_irq;

    axil_reg_bridge u_bridge (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .axil_req_i ( axil_req_i ),
        .axil_rsp_o ( axil_rsp_o ),
        .reg_req_o  ( bus_req    ),
        .reg_rsp_i  ( bus_rsp    )
    );

    reg_demux u_demux (
        .reg_req_i   ( bus_req   ),
        .reg_rsp_o   ( bus_rsp   ),
        .plic_req_o  ( plic_req  ),
        .plic_rsp_i  ( plic_rsp  ),
        .timer_req_o ( timer_req ),
        .timer_rsp_i ( timer_rsp )
    );

    timer_unit u_timer (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .reg_req_i ( timer_req ),
        .reg_rsp_o ( timer_rsp ),
        .irq_o     ( timer_irq )
    );

    // Sources 1 to 4 are the timer flags, 5 and 6 the external pins
    plic_regs u_plic (
        .clk_i     ( clk_i                  ),
        .rst_n_i   ( rst_n_i                ),
        .reg_req_i ( plic_req               ),
        .reg_rsp_o ( plic_rsp               ),
        .src_i     ( {ext_irq_i, timer_irq} ),
        .irq_o     ( irq_o                  )
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 100 ns clock, reset held low for the first three rising edges
 */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== tests/tb_periph.sv ====
/*
 * Testbench for the peripheral subsystem
 * AXI4-Lite accesses, timer interrupts and PLIC claim/complete
 */
module tb_periph;
    timeunit 1ns;
    timeprecision 100ps;
    import periph_pkg::*;

    localparam int         Timeout   = 100;
    localparam int         PollLimit = 40;
    localparam logic [1:0] Okay      = 2'b00;
    localparam logic [1:0] SlvErr    = 2'b10;

    logic        clk;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [1:0]  ext_irq;
    logic [1:0]  irq;

    string       cur_test;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          seed = 66;
    logic [31:0] cmp_val;

    tb_clock_gen u_clock_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    periph_subsystem dut (
        .clk_i      ( clk      ),
        .rst_n_i    ( rst_n    ),
        .axil_req_i ( axil_req ),
        .axil_rsp_o ( axil_rsp ),
        .ext_irq_i  ( ext_irq  ),
        .irq_o      ( irq      )
    );

    // ------------------------------
    // Checking and reporting
    // ------------------------------
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %s, %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("Test %s: ok", cur_test);
        end else begin
            $display("Test %s: %0d error(s)", cur_test, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout in test %s: %s did not happen in time", cur_test, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // ------------------------------
    // AXI4-Lite master
    // ------------------------------
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int   cycles;
        logic aw_fire;
        logic w_fire;
        @(posedge clk);
        axil_req.aw_valid <= 1'b1;
        axil_req.aw_addr  <= addr;
        axil_req.w_valid  <= 1'b1;
        axil_req.w_data   <= data;
        axil_req.w_strb   <= 4'hF;
        cycles = 0;
        // AW and W may finish on different edges
        @(negedge clk);
        while ((axil_req.aw_valid || axil_req.w_valid) && cycles < Timeout) begin
            aw_fire = axil_req.aw_valid && axil_rsp.aw_ready;
            w_fire  = axil_req.w_valid && axil_rsp.w_ready;
            @(posedge clk);
            if (aw_fire) axil_req.aw_valid <= 1'b0;
            if (w_fire) axil_req.w_valid <= 1'b0;
            @(negedge clk);
            cycles++;
        end
        if (axil_req.aw_valid || axil_req.w_valid) begin
            stop_on_timeout("write address and data handshake");
        end
        cycles = 0;
        while (!axil_rsp.b_valid && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.b_valid) stop_on_timeout("write response");
        resp = axil_rsp.b_resp;
        @(posedge clk);
    endtask

    // Hold keeps r_ready low for that many cycles after r_valid rises
    task automatic axil_read(input logic [15:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int cycles;
        @(posedge clk);
        axil_req.ar_valid <= 1'b1;
        axil_req.ar_addr  <= addr;
        axil_req.r_ready  <= (hold == 0);
        cycles = 0;
        @(negedge clk);
        while (!axil_rsp.ar_ready && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.ar_ready) stop_on_timeout("read address handshake");
        @(posedge clk);
        axil_req.ar_valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!axil_rsp.r_valid && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.r_valid) stop_on_timeout("read response");
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            if (i == hold - 1) axil_req.r_ready <= 1'b1;
            @(negedge clk);
            check_value("r_valid under back-pressure", 32'd1, 32'(axil_rsp.r_valid));
            check_value("r_data under back-pressure", data, axil_rsp.r_data);
        end
        @(posedge clk);
    endtask

    task automatic write_check(input logic [15:0] addr, input logic [31:0] data,
                               input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_value($sformatf("write resp at %h", addr), 32'(exp_resp), 32'(resp));
    endtask

    task automatic read_check(input logic [15:0] addr, input int hold,
                              input logic [31:0] exp_data, input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, hold, data, resp);
        check_value($sformatf("read data at %h", addr), exp_data, data);
        check_value($sformatf("read resp at %h", addr), 32'(exp_resp), 32'(resp));
    endtask

    // Repeated reads until one status bit sets
    task automatic poll_status(input logic [15:0] addr, input int bit_idx, input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        int          reads;
        reads = 0;
        axil_read(addr, 0, data, resp);
        while (!data[bit_idx] && reads < PollLimit) begin
            axil_read(addr, 0, data, resp);
            reads++;
        end
        if (!data[bit_idx]) stop_on_timeout(what);
    endtask

    task automatic wait_irq(input int idx, input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (irq[idx] !== level && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (irq[idx] !== level) stop_on_timeout(what);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int          cycles;
        int          hold;
        logic [31:0] data;
        logic [1:0]  resp;
        axil_req         = '0;
        axil_req.b_ready = 1'b1;
        axil_req.r_ready = 1'b1;
        ext_irq          = 2'b00;
        cur_test         = "reset";

        cycles = 0;
        @(negedge clk);
        while (!rst_n && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) stop_on_timeout("reset release");

        start_test("reset");
        check_value("ready signals", 32'h7,
                    32'({axil_rsp.aw_ready, axil_rsp.w_ready, axil_rsp.ar_ready}));
        check_value("response valids", 32'h0, 32'({axil_rsp.b_valid, axil_rsp.r_valid}));
        check_value("irq_o", 32'h0, 32'(irq));
        end_test();

        start_test("readback");
        cmp_val = $random(seed);
        write_check(16'h1004, cmp_val, Okay);
        read_check(16'h1004, 0, cmp_val, Okay);
        // Priority keeps only its low three bits
        write_check(16'h0008, 32'hF, Okay);
        read_check(16'h0008, 0, 32'h7, Okay);
        end_test();

        start_test("unmapped");
        write_check(16'h5000, 32'h1234_5678, SlvErr);
        read_check(16'h5000, 0, 32'hDEAD_BEEF, SlvErr);
        end_test();

        start_test("timer_match");
        write_check(16'h1004, 32'd20, Okay);
        write_check(16'h1008, 32'd3, Okay);
        poll_status(16'h100C, 0, "timer 0 match flag");
        axil_read(16'h0080, 0, data, resp);
        check_value("pending source 1", 32'd1, 32'(data[0]));
        // Stopped so the next match cannot set the flag again before the readback
        write_check(16'h1008, 32'd0, Okay);
        write_check(16'h100C, 32'd1, Okay);
        axil_read(16'h100C, 0, data, resp);
        check_value("match flag after clear", 32'd0, 32'(data[0]));
        end_test();

        start_test("overflow");
        write_check(16'h1010, 32'hFFFF_FFF0, Okay);
        write_check(16'h1018, 32'd1, Okay);
        poll_status(16'h101C, 1, "timer 1 overflow flag");
        axil_read(16'h0080, 0, data, resp);
        check_value("pending source 4", 32'd1, 32'(data[3]));
        end_test();

        start_test("claim");
        write_check(16'h0014, 32'd2, Okay);
        write_check(16'h0018, 32'd5, Okay);
        write_check(16'h0100, 32'h30, Okay);
        write_check(16'h0104, 32'h30, Okay);
        write_check(16'h0200, 32'd1, Okay);
        write_check(16'h0210, 32'd7, Okay);
        @(posedge clk);
        ext_irq <= 2'b11;
        wait_irq(0, 1'b1, "irq_o[0] rising");
        check_value("irq_o[1] with threshold 7", 32'd0, 32'(irq[1]));
        // Source 6 has the higher priority
        read_check(16'h0204, 0, 32'd6, Okay);
        read_check(16'h0204, 0, 32'd5, Okay);
        @(posedge clk);
        ext_irq <= 2'b00;
        write_check(16'h0204, 32'd6, Okay);
        write_check(16'h0204, 32'd5, Okay);
        wait_irq(0, 1'b0, "irq_o[0] falling");
        end_test();

        start_test("back_pressure");
        write_check(16'h1004, cmp_val, Okay);
        for (int i = 0; i < 8; i++) begin
            hold = $unsigned($random(seed)) % 8;
            if ($random(seed) & 1) begin
                read_check(16'h1004, hold, cmp_val, Okay);
            end else begin
                read_check(16'h0008, hold, 32'h7, Okay);
            end
        end
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== periph.f ====
common/periph_pkg.sv
verilog/axil_reg_bridge.sv
verilog/reg_demux.sv
timer/timer_unit.sv
plic/plic_gateway.sv
plic/plic_target.sv
plic/plic_regs.sv
verilog/periph_subsystem.sv
tests/tb_clock_gen.sv
tests/tb_periph.sv
